//--- exec_wb.f
+incdir+source
+incdir+tb
source/exec_pkg.sv
source/issue_ctrl.sv
source/reg_file.sv
source/alu_stage.sv
source/mult_pipe.sv
source/wb_merge.sv
source/exec_wb_top.sv
tb/exec_wb_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module exec_wb_tb \
   -f exec_wb.f -Mdir obj_dir -o exec_wb_sim \
   || { echo "Verilator build error"; exit 1; }
./obj_dir/exec_wb_sim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -qx "Testbench passed" sim.log && exit 0 || exit 1

//--- tb/exec_wb_checks.svh
`ifndef EXEC_WB_CHECKS_SVH
`define EXEC_WB_CHECKS_SVH

// One outstanding register write, kept in program order
typedef struct packed {
   reg_addr_t dest;
   word_t     data;
   int        acc_edge;
   int        lat;
} pend_t;

pend_t     pend[$];
reg_addr_t wb_order[$];          // Registers in write-back order
word_t     model_regs [`NUM_REGS];
int        err_count     = 0;
int        check_count   = 0;
int        test_count    = 0;
int        issued_writes = 0;

task automatic note_error(input string msg);
   $display("%s", msg);
   err_count++;
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
   check_count++;
   if (got !== exp) begin
      $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
      err_count++;
   end
endtask

task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
   check_count++;
   if (got !== exp) begin
      $display("ERR %s: got 0x%02h expected 0x%02h", name, got, exp);
      err_count++;
   end
endtask

// Architectural effect of one instruction on the shadow registers
function automatic void predict(input instr_u ins, output bit writes, output reg_addr_t dst,
                                output word_t val, output int lat);
   word_t a;
   word_t b;
   a      = model_regs[ins.r.rs];
   b      = model_regs[ins.r.rt];
   writes = 1'b1;
   dst    = ins.r.rd;
   val    = '0;
   lat    = 2;
   if (ins.i.opcode == `OP_ADDI) begin
      dst = ins.i.rt;
      val = a + {{16{ins.i.imm[15]}}, ins.i.imm};
   end else if (ins.r.opcode != `OP_RTYPE) begin
      writes = 1'b0;             // Unknown opcode
   end else begin
      case (ins.r.funct)
         `FN_ADD: val = a + b;
         `FN_SUB: val = a - b;
         `FN_AND: val = a & b;
         `FN_OR:  val = a | b;
         `FN_MUL: begin
            val = a * b;         // Low word of the product
            lat = 6;
         end
         default: writes = 1'b0;
      endcase
   end
   if (dst == '0) begin
      writes = 1'b0;
   end
endfunction

`endif

//--- tb/exec_wb_tb.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_wb_tb;
   import exec_pkg::*;

   localparam int HALF_PERIOD = 50;
   localparam int TIMEOUT     = 40;   // Cycles, per wait

   logic      clk;
   logic      mem_wb_reset;
   logic      in_valid;
   logic      in_ready;
   instr_u    in_instr;
   logic      wb_valid;
   reg_addr_t wb_reg;
   word_t     wb_data;

   `include "exec_wb_checks.svh"

   exec_wb_top exec_wb_top_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_instr     (in_instr),
      .wb_valid     (wb_valid),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data)
   );

   always #HALF_PERIOD clk = ~clk;

   // Index of the latest rising edge
   function automatic int edge_index();
      return int'(($time - HALF_PERIOD) / (2 * HALF_PERIOD));
   endfunction

   function automatic instr_u r_instr(input logic [5:0] fn, input reg_addr_t rs,
                                      input reg_addr_t rt, input reg_addr_t rd);
      instr_u ins;
      ins.r = {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
      return ins;
   endfunction

   function automatic instr_u i_instr(input reg_addr_t rs, input reg_addr_t rt,
                                      input logic [15:0] imm);
      instr_u ins;
      ins.i = {`OP_ADDI, rs, rt, imm};
      return ins;
   endfunction

   function automatic reg_addr_t rand_reg(input int lo, input int hi);
      return reg_addr_t'($urandom_range(hi, lo));
   endfunction

   function automatic logic [5:0] pick_fn(input int sel);
      case (sel)
         0:       return `FN_ADD;
         1:       return `FN_SUB;
         2:       return `FN_AND;
         3:       return `FN_OR;
         default: return `FN_MUL;
      endcase
   endfunction

   task automatic stop_on_timeout(input string what);
      note_error($sformatf("Timeout: %s", what));
      $display("Testbench failed");
      $finish;
   endtask

   // Write-back outputs are flops, steady at the falling edge
   always @(negedge clk) begin
      int idx;
      idx = -1;
      if (wb_valid === 1'b1) begin
         if (mem_wb_reset) begin
            note_error("write-back seen while reset was high");
         end
         for (int k = 0; k < pend.size(); k++) begin
            if (idx < 0 && pend[k].dest == wb_reg) begin
               idx = k;       // Oldest pending write to this register
            end
         end
         if (idx < 0) begin
            note_error($sformatf("write-back to r%0d with nothing pending", wb_reg));
         end else begin
            check_word("wb_data", wb_data, pend[idx].data);
            if (edge_index() - pend[idx].acc_edge != pend[idx].lat) begin
               note_error($sformatf("r%0d written %0d cycles after acceptance, not %0d",
                                    wb_reg, edge_index() - pend[idx].acc_edge, pend[idx].lat));
            end
            wb_order.push_back(wb_reg);
            pend.delete(idx);
         end
      end
   end

   task automatic send_instr(input instr_u ins, output int acc_edge);
      int        waited;
      bit        writes;
      reg_addr_t dst;
      word_t     val;
      int        lat;
      pend_t     entry;
      waited = 0;
      @(negedge clk);
      in_valid = 1'b1;
      in_instr = ins;
      #10;
      while (!in_ready && waited < TIMEOUT) begin
         waited++;
         @(negedge clk);
         #10;
      end
      if (!in_ready) begin
         stop_on_timeout("in_ready stayed low");
      end else begin
         @(posedge clk);
         acc_edge = edge_index();
         predict(ins, writes, dst, val, lat);
         if (writes) begin
            model_regs[dst] = val;
            entry.dest      = dst;
            entry.data      = val;
            entry.acc_edge  = acc_edge;
            entry.lat       = lat;
            pend.push_back(entry);
            issued_writes++;
         end
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      @(negedge clk);
      in_valid = 1'b0;
      while (pend.size() != 0 && waited < TIMEOUT) begin
         waited++;
         @(posedge clk);
      end
      if (pend.size() != 0) begin
         stop_on_timeout("write-backs still pending");
      end else begin
         repeat (3) @(posedge clk);   // Room for a stray write-back
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_count++;
      if (err_count == errs_before) begin
         $display("test %-12s ok", name);
      end else begin
         $display("test %-12s %0d errors", name, err_count - errs_before);
      end
   endtask

   task automatic test_addi_loads();
      int errs;
      int acc;
      errs = err_count;
      for (int r = 1; r <= 8; r++) begin
         send_instr(i_instr(5'd0, reg_addr_t'(r), 16'($urandom())), acc);
      end
      send_instr(i_instr(5'd0, 5'd0, 16'h7fff), acc);   // To r0, no write-back
      wait_drain();
      end_test("addi_loads", errs);
   endtask

   task automatic test_alu_ops();
      int errs;
      int acc;
      errs = err_count;
      for (int k = 0; k < 12; k++) begin
         send_instr(r_instr(pick_fn(k % 4), rand_reg(1, 8), rand_reg(1, 8), rand_reg(9, 15)),
                    acc);
      end
      wait_drain();
      end_test("alu_ops", errs);
   endtask

   task automatic test_single_mul();
      int errs;
      int acc;
      errs = err_count;
      wb_order.delete();
      send_instr(r_instr(`FN_MUL, 5'd1, 5'd2, 5'd9), acc);
      send_instr(i_instr(5'd3, 5'd10, 16'($urandom())), acc);
      wait_drain();
      check_reg("wb_reg", wb_order[0], 5'd10);   // ADDI overtakes the MUL
      check_reg("wb_reg", wb_order[1], 5'd9);
      end_test("single_mul", errs);
   endtask

   task automatic test_mul_pipeline();
      int errs;
      int acc;
      int first;
      errs = err_count;
      wb_order.delete();
      for (int k = 0; k < 5; k++) begin
         send_instr(r_instr(`FN_MUL, rand_reg(1, 8), rand_reg(1, 8), reg_addr_t'(11 + k)), acc);
         if (k == 0) begin
            first = acc;
         end else if (acc != first + k) begin
            note_error($sformatf("MUL %0d accepted at edge %0d, not %0d", k, acc, first + k));
         end
      end
      wait_drain();
      for (int k = 0; k < 5; k++) begin
         check_reg("wb_reg", wb_order[k], reg_addr_t'(11 + k));   // Issue order
      end
      end_test("mul_pipeline", errs);
   endtask

   task automatic test_raw_chain();
      int errs;
      int acc_mul;
      int acc_add;
      int acc_sub;
      errs = err_count;
      send_instr(r_instr(`FN_MUL, 5'd4, 5'd5, 5'd12), acc_mul);
      send_instr(r_instr(`FN_ADD, 5'd12, 5'd6, 5'd13), acc_add);
      send_instr(r_instr(`FN_SUB, 5'd13, 5'd7, 5'd14), acc_sub);
      wait_drain();
      if (acc_add != acc_mul + 7 || acc_sub != acc_add + 3) begin
         note_error("dependent instruction not held until its source was written");
      end
      end_test("raw_chain", errs);
   endtask

   task automatic test_mixed();
      int        errs;
      int        acc;
      int        sel;
      int        writes_before;
      reg_addr_t dst;
      instr_u    ins;
      errs          = err_count;
      writes_before = issued_writes;
      wb_order.delete();
      for (int k = 0; k < 40; k++) begin
         dst = rand_reg(8, 15);
         if (dst == 5'd8) begin
            dst = 5'd0;
         end
         sel = $urandom_range(7, 0);
         case (sel)
            6:       ins = i_instr(rand_reg(1, 8), dst, 16'($urandom()));
            7:       ins = r_instr(6'h3f, rand_reg(1, 8), rand_reg(1, 8), dst);  // Unknown funct
            default: ins = r_instr(pick_fn(sel), rand_reg(1, 8), rand_reg(1, 8), dst);
         endcase
         send_instr(ins, acc);
      end
      wait_drain();
      if (wb_order.size() != issued_writes - writes_before) begin
         note_error($sformatf("%0d write-backs seen for %0d register writes",
                              wb_order.size(), issued_writes - writes_before));
      end
      end_test("mixed", errs);
   endtask

   initial begin
      void'($urandom(32'h7543));
      clk          = 1'b0;
      mem_wb_reset = 1'b1;
      in_valid     = 1'b0;
      in_instr     = '0;
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      repeat (8) @(negedge clk);
      mem_wb_reset = 1'b0;
      test_addi_loads();
      test_alu_ops();
      test_single_mul();
      test_mul_pipeline();
      test_raw_chain();
      test_mixed();
      $display("tests %0d  checks %0d  errors %0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- source/exec_wb_top.sv
`timescale 1ns/1ps

module exec_wb_top (
   input  logic                clk,
   input  logic                mem_wb_reset,
   input  logic                in_valid,
   output logic                in_ready,
   input  exec_pkg::instr_u    in_instr,
   output logic                wb_valid,
   output exec_pkg::reg_addr_t wb_reg,
   output exec_pkg::word_t     wb_data
);
   import exec_pkg::*;

   // Issue to execute units
   reg_addr_t rs_addr;
   reg_addr_t rt_addr;
   logic      alu_issue;
   logic      mul_issue;
   reg_addr_t issue_dest;
   alu_op_e   alu_op;
   logic      use_imm;
   word_t     imm;

   // Operands
   word_t     rs_data;
   word_t     rt_data;

   // Unit results
   logic      alu_valid;
   reg_addr_t alu_dest;
   word_t     alu_result;
   logic      mul_valid;
   reg_addr_t mul_dest;
   word_t     mul_result;

   issue_ctrl issue_ctrl_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_instr     (in_instr),
      .rs_addr      (rs_addr),
      .rt_addr      (rt_addr),
      .alu_issue    (alu_issue),
      .mul_issue    (mul_issue),
      .issue_dest   (issue_dest),
      .alu_op       (alu_op),
      .use_imm      (use_imm),
      .imm          (imm),
      .wb_valid     (wb_valid),   // Scoreboard clear
      .wb_reg       (wb_reg)
   );

   reg_file reg_file_i (
      .clk      (clk),
      .rs_addr  (rs_addr),
      .rt_addr  (rt_addr),
      .rs_data  (rs_data),
      .rt_data  (rt_data),
      .wb_valid (wb_valid),
      .wb_reg   (wb_reg),
      .wb_data  (wb_data)
   );

   alu_stage alu_stage_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .alu_issue    (alu_issue),
      .issue_dest   (issue_dest),
      .alu_op       (alu_op),
      .use_imm      (use_imm),
      .imm          (imm),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .alu_valid    (alu_valid),
      .alu_dest     (alu_dest),
      .alu_result   (alu_result)
   );

   mult_pipe mult_pipe_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .mul_issue    (mul_issue),
      .issue_dest   (issue_dest),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .mul_valid    (mul_valid),
      .mul_dest     (mul_dest),
      .mul_result   (mul_result)
   );

   wb_merge wb_merge_i (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .alu_valid    (alu_valid),
      .alu_dest     (alu_dest),
      .alu_result   (alu_result),
      .mul_valid    (mul_valid),
      .mul_dest     (mul_dest),
      .mul_result   (mul_result),
      .wb_valid     (wb_valid),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data)
   );

endmodule

//--- source/wb_merge.sv
`timescale 1ns/1ps

module wb_merge (
   input  logic                clk,
   input  logic                mem_wb_reset,
   input  logic                alu_valid,
   input  exec_pkg::reg_addr_t alu_dest,
   input  exec_pkg::word_t     alu_result,
   input  logic                mul_valid,
   input  exec_pkg::reg_addr_t mul_dest,
   input  exec_pkg::word_t     mul_result,
   output logic                wb_valid,
   output exec_pkg::reg_addr_t wb_reg,
   output exec_pkg::word_t     wb_data
);

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= alu_valid | mul_valid;
      end
   end

   // Issue logic keeps the two sources apart, ALU side chosen when set
   always_ff @(posedge clk) begin
      if (alu_valid) begin
         wb_reg  <= alu_dest;
         wb_data <= alu_result;
      end else begin
         wb_reg  <= mul_dest;
         wb_data <= mul_result;
      end
   end

endmodule

//--- source/mult_pipe.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module mult_pipe (
   input  logic                clk,
   input  logic                mem_wb_reset,
   input  logic                mul_issue,
   input  exec_pkg::reg_addr_t issue_dest,
   input  exec_pkg::word_t     rs_data,
   input  exec_pkg::word_t     rt_data,
   output logic                mul_valid,
   output exec_pkg::reg_addr_t mul_dest,
   output exec_pkg::word_t     mul_result
);
   import exec_pkg::*;

   // Stage 0 latches operands, each later stage adds one multiplier slice
   localparam int    CHUNK = `WORD_W / (`MULT_STAGES - 1);
   localparam word_t MASK  = word_t'({CHUNK{1'b1}});

   logic [`MULT_STAGES-1:0] st_valid;
   reg_addr_t st_dest [`MULT_STAGES];
   word_t     st_a    [`MULT_STAGES-1];
   word_t     st_b    [`MULT_STAGES-1];
   word_t     st_acc  [1:`MULT_STAGES-1];   // Partial sums

   // Slice k of b times a, shifted into place, low word only
   function automatic word_t part_prod(input word_t a, input word_t b, input int k);
      word_t slice;
      slice = (b >> (k * CHUNK)) & MASK;
      return (a * slice) << (k * CHUNK);
   endfunction

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         st_valid <= '0;
      end else begin
         st_valid <= {st_valid[`MULT_STAGES-2:0], mul_issue};
      end
   end

   always_ff @(posedge clk) begin
      st_dest[0] <= issue_dest;
      st_a[0]    <= rs_data;
      st_b[0]    <= rt_data;
      st_acc[1]  <= part_prod(st_a[0], st_b[0], 0);
      for (int s = 1; s < `MULT_STAGES; s++) begin
         st_dest[s] <= st_dest[s-1];
      end
      for (int s = 1; s < `MULT_STAGES - 1; s++) begin
         st_a[s] <= st_a[s-1];
         st_b[s] <= st_b[s-1];
      end
      for (int s = 2; s < `MULT_STAGES; s++) begin
         st_acc[s] <= st_acc[s-1] + part_prod(st_a[s-1], st_b[s-1], s - 1);
      end
   end

   assign mul_valid  = st_valid[`MULT_STAGES-1];
   assign mul_dest   = st_dest[`MULT_STAGES-1];
   assign mul_result = st_acc[`MULT_STAGES-1];

endmodule

//--- source/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
   input  logic                clk,
   input  logic                mem_wb_reset,
   input  logic                alu_issue,
   input  exec_pkg::reg_addr_t issue_dest,
   input  exec_pkg::alu_op_e   alu_op,
   input  logic                use_imm,
   input  exec_pkg::word_t     imm,
   input  exec_pkg::word_t     rs_data,
   input  exec_pkg::word_t     rt_data,
   output logic                alu_valid,
   output exec_pkg::reg_addr_t alu_dest,
   output exec_pkg::word_t     alu_result
);
   import exec_pkg::*;

   word_t op_b;
   word_t result;

   assign op_b = use_imm ? imm : rt_data;   // ADDI takes the immediate

   always_comb begin
      case (alu_op)
         ALU_ADD: result = rs_data + op_b;
         ALU_SUB: result = rs_data - op_b;
         ALU_AND: result = rs_data & op_b;
         ALU_OR:  result = rs_data | op_b;
         default: result = rs_data + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         alu_valid <= 1'b0;
      end else begin
         alu_valid <= alu_issue;
      end
   end

   // Result and destination, tagged by alu_valid
   always_ff @(posedge clk) begin
      alu_dest   <= issue_dest;
      alu_result <= result;
   end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module reg_file (
   input  logic                clk,
   input  exec_pkg::reg_addr_t rs_addr,
   input  exec_pkg::reg_addr_t rt_addr,
   output exec_pkg::word_t     rs_data,
   output exec_pkg::word_t     rt_data,
   input  logic                wb_valid,
   input  exec_pkg::reg_addr_t wb_reg,
   input  exec_pkg::word_t     wb_data
);
   import exec_pkg::*;

   word_t regs [`NUM_REGS];

   // r0 is never written
   always_ff @(posedge clk) begin
      if (wb_valid && (wb_reg != '0)) begin
         regs[wb_reg] <= wb_data;
      end
   end

   // Read ports, r0 forced to zero
   always_comb begin
      if (rs_addr == '0) begin
         rs_data = '0;
      end else begin
         rs_data = regs[rs_addr];
      end
   end

   always_comb begin
      if (rt_addr == '0) begin
         rt_data = '0;
      end else begin
         rt_data = regs[rt_addr];
      end
   end

endmodule

//--- source/issue_ctrl.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module issue_ctrl (
   input  logic                clk,
   input  logic                mem_wb_reset,
   input  logic                in_valid,
   output logic                in_ready,
   input  exec_pkg::instr_u    in_instr,
   output exec_pkg::reg_addr_t rs_addr,
   output exec_pkg::reg_addr_t rt_addr,
   output logic                alu_issue,
   output logic                mul_issue,
   output exec_pkg::reg_addr_t issue_dest,
   output exec_pkg::alu_op_e   alu_op,
   output logic                use_imm,
   output exec_pkg::word_t     imm,
   input  logic                wb_valid,
   input  exec_pkg::reg_addr_t wb_reg
);
   import exec_pkg::*;

   // MUL issued this many cycles before an ALU op hits write-back together
   localparam int HIST = `MULT_STAGES - 1;

   logic [`NUM_REGS-1:0] busy;
   logic [`NUM_REGS-1:0] busy_now;
   logic [`NUM_REGS-1:0] wb_clear;
   logic [`NUM_REGS-1:0] set_mask;
   logic [HIST-1:0]      mul_hist;   // Bit 0 is the most recent edge

   logic      is_rtype;
   logic      is_addi;
   logic      is_alu;
   logic      is_mul;
   logic      do_alu;
   logic      do_mul;
   logic      hazard;
   logic      collide;
   logic      accept;
   alu_op_e   dec_op;
   reg_addr_t dec_dest;

   always_comb begin
      is_rtype = in_instr.r.opcode == `OP_RTYPE;
      is_addi  = in_instr.i.opcode == `OP_ADDI;
      is_alu   = is_addi;
      is_mul   = 1'b0;
      dec_op   = ALU_ADD;
      if (is_rtype) begin
         case (in_instr.r.funct)
            `FN_ADD: is_alu = 1'b1;
            `FN_SUB: begin
               is_alu = 1'b1;
               dec_op = ALU_SUB;
            end
            `FN_AND: begin
               is_alu = 1'b1;
               dec_op = ALU_AND;
            end
            `FN_OR: begin
               is_alu = 1'b1;
               dec_op = ALU_OR;
            end
            `FN_MUL: is_mul = 1'b1;
            default: ;             // Unknown funct, dropped
         endcase
      end
      dec_dest = is_rtype ? in_instr.r.rd : in_instr.i.rt;
   end

   // Writes to r0 go nowhere
   assign do_alu = is_alu && (dec_dest != '0);
   assign do_mul = is_mul && (dec_dest != '0);

   // A register in write-back this cycle counts as free
   assign wb_clear = {{(`NUM_REGS-1){1'b0}}, wb_valid} << wb_reg;
   assign busy_now = busy & ~wb_clear;

   assign hazard = (do_alu || do_mul) &&
                   (busy_now[in_instr.r.rs] ||
                    (is_rtype && busy_now[in_instr.r.rt]) ||
                    busy_now[dec_dest]);
   assign collide = do_alu && mul_hist[HIST-1];

   assign in_ready = !mem_wb_reset && !hazard && !collide;
   assign accept   = in_valid && in_ready;
   assign set_mask = {{(`NUM_REGS-1){1'b0}}, accept && (do_alu || do_mul)} << dec_dest;

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         busy      <= '0;
         mul_hist  <= '0;
         alu_issue <= 1'b0;
         mul_issue <= 1'b0;
      end else begin
         busy      <= busy_now | set_mask;
         mul_hist  <= {mul_hist[HIST-2:0], accept && do_mul};
         alu_issue <= accept && do_alu;
         mul_issue <= accept && do_mul;
      end
   end

   // Fields held for the operand read in the next cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         rs_addr    <= in_instr.r.rs;
         rt_addr    <= in_instr.r.rt;
         issue_dest <= dec_dest;
         alu_op     <= dec_op;
         use_imm    <= is_addi;
         imm        <= {{(`WORD_W-16){in_instr.i.imm[15]}}, in_instr.i.imm};
      end
   end

endmodule

//--- source/exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`REG_AW-1:0] reg_addr_t;

   // R-type layout
   typedef struct packed {
      logic [5:0] opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } rtype_t;

   // I-type layout, rt is the destination
   typedef struct packed {
      logic [5:0]  opcode;
      reg_addr_t   rs;
      reg_addr_t   rt;
      logic [15:0] imm;
   } itype_t;

   // Same instruction word, read either way
   typedef union packed {
      rtype_t r;
      itype_t i;
   } instr_u;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR
   } alu_op_e;

endpackage

//--- source/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath widths
`define WORD_W       32
`define REG_AW       5
`define NUM_REGS     32

// Multiply pipeline depth, one register per stage
`define MULT_STAGES  5

// Primary opcodes, 6 bits
`define OP_RTYPE     6'd0
`define OP_ADDI      6'd8

// R-type function codes
`define FN_ADD       6'h20
`define FN_SUB       6'h22
`define FN_AND       6'h24
`define FN_OR        6'h25
`define FN_MUL       6'h18

`endif
